//--- lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN   = 32;       // data and address width
  localparam int unsigned BE_W   = XLEN / 8; // byte enables per word
  localparam int unsigned OFFS_W = 2;        // byte offset inside a word

  ////////////////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////////////////

  // access size, both 1x codes mean byte
  typedef enum logic [1:0] {
    SIZE_WORD    = 2'b00,
    SIZE_HALF    = 2'b01,
    SIZE_BYTE    = 2'b10,
    SIZE_BYTE_HI = 2'b11
  } lsu_size_e;

  // fill used above a loaded byte or halfword
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } lsu_ext_e;

  ////////////////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////////////////

  // one request from the EX stage
  typedef struct packed {
    logic              we;         // store when high
    lsu_size_e         size;
    lsu_ext_e          ext;        // only meaningful for loads
    logic [XLEN-1:0]   wdata;      // register value to store
    logic [OFFS_W-1:0] reg_offset; // byte position of the data inside the register
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
    logic              use_incr;   // address is a + b, else a alone
  } lsu_req_t;

  // what goes onto the memory bus
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

  // load details needed again when rvalid comes back
  typedef struct packed {
    lsu_size_e         size;
    lsu_ext_e          ext;
    logic [OFFS_W-1:0] offset;
  } load_ctx_t;

  // memory word, seen as bytes or as halfwords
  typedef union packed {
    logic [BE_W-1:0][7:0]    b;
    logic [BE_W/2-1:0][15:0] h;
  } mem_word_u;

endpackage

//--- lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*;
(
  input  lsu_req_t          req_i,        // request from EX
  output mem_req_t          mem_req_o,    // address, we, be, rotated data
  output logic [OFFS_W-1:0] offset_o,     // low address bits
  output logic              misaligned_o  // access crosses a word boundary
);

  logic [XLEN-1:0]   addr;
  logic [OFFS_W-1:0] offset;
  logic [OFFS_W-1:0] wdata_offset;  // byte rotation amount
  logic [BE_W-1:0]   be;
  logic [XLEN-1:0]   wdata;

  // address generation
  assign addr   = req_i.use_incr ? (req_i.op_a + req_i.op_b) : req_i.op_a;
  assign offset = addr[OFFS_W-1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      SIZE_WORD: be = 4'b1111;           // only legal at offset 0
      SIZE_HALF:
      begin
        case (offset)
          2'b00:   be = 4'b0011;
          2'b01:   be = 4'b0110;
          default: be = 4'b1100;         // offset 3 is rejected anyway
        endcase
      end
      SIZE_BYTE,
      SIZE_BYTE_HI: be = 4'b0001 << offset; // one lane
      default: be = 4'b0000;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // store data rotation
  //////////////////////////////////////////////////////////////////////

  // move the register byte at reg_offset onto the addressed lane
  assign wdata_offset = offset - req_i.reg_offset; // wraps modulo 4

  always_comb
  begin
    case (wdata_offset)
      2'b00: wdata = req_i.wdata;
      2'b01: wdata = {req_i.wdata[23:0], req_i.wdata[31:24]}; // left by one byte
      2'b10: wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'b11: wdata = {req_i.wdata[7:0],  req_i.wdata[31:8]};
    endcase
  end

  // word off a boundary, or halfword spilling into the next word
  assign misaligned_o = ((req_i.size == SIZE_WORD) && (offset != 2'b00)) ||
                        ((req_i.size == SIZE_HALF) && (offset == 2'b11));

  assign mem_req_o = '{addr: addr, we: req_i.we, be: be, wdata: wdata};
  assign offset_o  = offset;

endmodule

//--- lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*;
(
  input  mem_word_u       rdata_i,  // raw word from memory
  input  load_ctx_t       ctx_i,    // size, ext and offset taken at grant
  output logic [XLEN-1:0] data_o    // aligned and extended result
);

  logic [7:0]  byte_sel;   // addressed byte
  logic [15:0] half_sel;   // addressed halfword
  logic        byte_fill;  // bit copied above the byte
  logic        half_fill;  // bit copied above the halfword

  //////////////////////////////////////////////////////////////////////
  // lane selection
  //////////////////////////////////////////////////////////////////////

  assign byte_sel = rdata_i.b[ctx_i.offset];

  always_comb
  begin
    case (ctx_i.offset)
      2'b00:   half_sel = rdata_i.h[0];
      2'b01:   half_sel = {rdata_i.b[2], rdata_i.b[1]}; // straddles both halves
      default: half_sel = rdata_i.h[1];                 // offset 3 never issued
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // extension
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (ctx_i.ext)
      EXT_ZERO:
      begin
        byte_fill = 1'b0;
        half_fill = 1'b0;
      end
      EXT_ONES:
      begin
        byte_fill = 1'b1;
        half_fill = 1'b1;
      end
      EXT_SIGN:
      begin
        byte_fill = byte_sel[7];
        half_fill = half_sel[15];
      end
      default:
      begin
        // unused code 11 behaves like sign extension
        byte_fill = byte_sel[7];
        half_fill = half_sel[15];
      end
    endcase
  end

  always_comb
  begin
    case (ctx_i.size)
      SIZE_WORD:    data_o = rdata_i;                        // word passes as is
      SIZE_HALF:    data_o = {{16{half_fill}}, half_sel};
      SIZE_BYTE,
      SIZE_BYTE_HI: data_o = {{24{byte_fill}}, byte_sel};
      default:      data_o = rdata_i;
    endcase
  end

endmodule

//--- lsu_access_ctrl.sv
`timescale 1ns/1ps

module lsu_access_ctrl import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // EX side
  input  logic            req_i,           // core wants an access
  input  logic            misaligned_i,    // from the store aligner
  input  mem_req_t        mem_req_i,       // request built by the store aligner
  input  load_ctx_t       ctx_i,           // load context of the current request

  // memory side
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  output logic            data_req_o,
  output mem_req_t        data_req_bus_o,

  // load path
  input  logic [XLEN-1:0] aligned_i,       // extended word from the load aligner
  output load_ctx_t       ctx_o,           // context of the access in flight
  output logic [XLEN-1:0] rdata_o,         // value to the register file

  // status
  output logic            ready_ex_o,
  output logic            ready_wb_o,
  output logic            busy_o
);

  typedef enum logic {
    ST_IDLE,
    ST_WAIT   // granted, rvalid still to come
  } state_e;

  state_e          state_q, state_d;
  load_ctx_t       ctx_q;      // size/ext/offset of the access in flight
  logic            we_q;       // access in flight is a store
  logic [XLEN-1:0] rdata_q;    // last load result
  logic            can_issue;  // bus slot free this cycle
  logic            valid_req;  // request that may go out
  logic            granted;

  //////////////////////////////////////////////////////////////////////
  // request issue
  //////////////////////////////////////////////////////////////////////

  // one outstanding access; a new one may leave in the rvalid cycle
  assign can_issue = (state_q == ST_IDLE) || data_rvalid_i;
  assign valid_req = req_i && !misaligned_i;   // misaligned is never sent
  assign data_req_o     = can_issue && valid_req;
  assign granted        = data_req_o && data_gnt_i;
  assign data_req_bus_o = mem_req_i;

  // core holds its request until this goes high
  assign ready_ex_o = !valid_req || granted;
  assign ready_wb_o = (state_q == ST_IDLE) || data_rvalid_i;
  assign busy_o     = (state_q == ST_WAIT) || data_req_o;

  always_comb
  begin
    state_d = state_q;
    if (granted)
      state_d = ST_WAIT;            // new access in flight
    else if ((state_q == ST_WAIT) && data_rvalid_i)
      state_d = ST_IDLE;            // response done, nothing new
  end

  //////////////////////////////////////////////////////////////////////
  // state and context registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= ST_IDLE;
      ctx_q   <= '0;
      we_q    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (granted)
      begin
        ctx_q <= ctx_i;             // needed when rvalid returns
        we_q  <= mem_req_i.we;
      end
    end
  end

  // held result, only loads update it
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
      rdata_q <= aligned_i;
  end

  assign ctx_o   = ctx_q;
  assign rdata_o = (data_rvalid_i && !we_q) ? aligned_i : rdata_q; // bypass in rvalid cycle

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  // EX stage
  input  logic            req_i,
  input  lsu_req_t        lsu_req_i,
  output logic            ready_ex_o,
  output logic            ready_wb_o,
  output logic            misaligned_o,
  output logic [XLEN-1:0] rdata_o,
  output logic            busy_o,

  // memory bus
  output logic            data_req_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [BE_W-1:0] data_be_o,
  output logic [XLEN-1:0] data_wdata_o
);

  mem_req_t          mem_req;      // from the store aligner
  mem_req_t          bus_req;      // as driven to memory
  logic [OFFS_W-1:0] offset;
  logic              misaligned;
  load_ctx_t         ctx_next;     // context of the current EX request
  load_ctx_t         ctx_cur;      // context captured at grant
  logic [XLEN-1:0]   aligned;

  ////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////

  lsu_store_align u_store_align (
    .req_i        (lsu_req_i),
    .mem_req_o    (mem_req),
    .offset_o     (offset),
    .misaligned_o (misaligned)
  );

  assign ctx_next = '{size: lsu_req_i.size, ext: lsu_req_i.ext, offset: offset};

  lsu_load_align u_load_align (
    .rdata_i (data_rdata_i),  // viewed through the word union
    .ctx_i   (ctx_cur),
    .data_o  (aligned)
  );

  ////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////

  lsu_access_ctrl u_access_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .misaligned_i   (misaligned),
    .mem_req_i      (mem_req),
    .ctx_i          (ctx_next),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .data_req_bus_o (bus_req),
    .aligned_i      (aligned),
    .ctx_o          (ctx_cur),
    .rdata_o        (rdata_o),
    .ready_ex_o     (ready_ex_o),
    .ready_wb_o     (ready_wb_o),
    .busy_o         (busy_o)
  );

  assign misaligned_o = misaligned;
  assign data_addr_o  = bus_req.addr;
  assign data_we_o    = bus_req.we;
  assign data_be_o    = bus_req.be;
  assign data_wdata_o = bus_req.wdata;

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

  localparam int TMO = 50;  // cycles allowed for any single wait

  logic            clk;
  logic            rst_n;
  logic            req_i;
  lsu_req_t        lsu_req;
  logic            ready_ex_o;
  logic            ready_wb_o;
  logic            misaligned_o;
  logic [XLEN-1:0] rdata_o;
  logic            busy_o;
  logic            data_req_o;
  logic            data_gnt_i;
  logic            data_rvalid_i;
  logic [XLEN-1:0] data_rdata_i;
  logic [XLEN-1:0] data_addr_o;
  logic            data_we_o;
  logic [BE_W-1:0] data_be_o;
  logic [XLEN-1:0] data_wdata_o;

  logic [31:0] mem [16];      // responder memory
  logic [31:0] exp_mem [16];  // what memory should hold
  int          seed;
  int          errors;
  int          timeouts;
  int          gnt_cnt;       // request cycles left before the next grant
  int          rv_cnt;        // cycles left until rvalid
  logic        rv_pend;
  logic [31:0] rd_q;          // word returned with the pending rvalid
  logic [31:0] rd_word;
  logic        take;          // grant lands on the coming edge
  logic        stall_next;    // ask for the longest grant and rvalid delay
  logic        long_rv;

  lsu_top u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .lsu_req_i     (lsu_req),
    .ready_ex_o    (ready_ex_o),
    .ready_wb_o    (ready_wb_o),
    .misaligned_o  (misaligned_o),
    .rdata_o       (rdata_o),
    .busy_o        (busy_o),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_rdata_i  (data_rdata_i),
    .data_addr_o   (data_addr_o),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  always #2 clk = ~clk;  // 4 ns period

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic lsu_req_t make_req(logic we, lsu_size_e size, lsu_ext_e ext,
                                        logic [31:0] wdata, logic [1:0] reg_off,
                                        logic [31:0] a, logic [31:0] b, logic incr);
    lsu_req_t r;
    r.we         = we;
    r.size       = size;
    r.ext        = ext;
    r.wdata      = wdata;
    r.reg_offset = reg_off;
    r.op_a       = a;
    r.op_b       = b;
    r.use_incr   = incr;
    return r;
  endfunction

  function automatic logic [31:0] req_addr(lsu_req_t r);
    return r.use_incr ? r.op_a + r.op_b : r.op_a;  // a + b, or a alone
  endfunction

  function automatic logic [3:0] be_for(lsu_size_e size, logic [1:0] off);
    logic [3:0] res;
    case (size)
      SIZE_WORD: res = 4'b1111;
      SIZE_HALF: res = 4'b0011 << off;  // pair starting at the offset
      default:   res = 4'b0001 << off;
    endcase
    return res;
  endfunction

  function automatic logic [31:0] rotl_bytes(logic [31:0] d, logic [1:0] n);
    logic [63:0] t;
    t = {d, d} << (8 * n);
    return t[63:32];
  endfunction

  function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                              logic [3:0] be);
    logic [31:0] res;
    int          i;
    res = old;
    for (i = 0; i < 4; i++)
      if (be[i])
        res[8*i +: 8] = data[8*i +: 8];
    return res;
  endfunction

  function automatic logic [31:0] load_value(logic [31:0] word, lsu_size_e size,
                                             lsu_ext_e ext, logic [1:0] off);
    logic [31:0] s;
    logic        top;
    logic        fill;
    logic [31:0] res;
    s    = word >> (8 * off);                         // addressed lane to the bottom
    top  = (size == SIZE_HALF) ? s[15] : s[7];
    fill = (ext == EXT_ONES) ? 1'b1 : (ext == EXT_SIGN) ? top : 1'b0;
    if (size == SIZE_WORD)
      res = word;
    else if (size == SIZE_HALF)
      res = {{16{fill}}, s[15:0]};
    else
      res = {{24{fill}}, s[7:0]};
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory responder
  //////////////////////////////////////////////////////////////////////

  always
  begin
    @(negedge clk);
    take = rst_n && data_req_o && data_gnt_i;
    if (stall_next)
    begin
      gnt_cnt    = 3;
      long_rv    = 1'b1;
      stall_next = 1'b0;
    end
    else if (data_req_o && !data_gnt_i && gnt_cnt > 0)
      gnt_cnt = gnt_cnt - 1;                                 // count request cycles
    if (take)
    begin
      rd_word = mem[data_addr_o[5:2]];
      if (data_we_o)
        mem[data_addr_o[5:2]] = merge_bytes(rd_word, data_wdata_o, data_be_o);
    end
    @(posedge clk);
    #1;
    data_rvalid_i = 1'b0;
    data_rdata_i  = 32'hdead_beef;  // junk outside rvalid
    if (take)
    begin
      rv_pend = 1'b1;
      rv_cnt  = long_rv ? 3 : 1 + ($unsigned($random(seed)) % 3);
      rd_q    = rd_word;
      gnt_cnt = $unsigned($random(seed)) % 4;
      long_rv = 1'b0;
    end
    if (rv_pend)
    begin
      rv_cnt = rv_cnt - 1;
      if (rv_cnt == 0)
      begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = rd_q;
        rv_pend       = 1'b0;
      end
    end
    data_gnt_i = (gnt_cnt == 0);
  end

  //////////////////////////////////////////////////////////////////////
  // checks and waits
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      errors++;
      $display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: no %s came within %0d cycles", what, TMO);
  endtask

  // request must sit still on the bus until granted
  task automatic wait_grant(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output int stalls);
    int   n;
    logic done;
    stalls = 0;
    done   = 1'b0;
    for (n = 0; n < TMO && !done; n++)
    begin
      @(negedge clk);
      check_bit("data_req_o", data_req_o, 1'b1);
      check_bit("misaligned_o", misaligned_o, 1'b0);
      check_word("data_addr_o", data_addr_o, addr);
      check_bit("data_we_o", data_we_o, we);
      check_word("data_be_o", {28'b0, data_be_o}, {28'b0, be});
      if (we)
        check_word("data_wdata_o", data_wdata_o, wdata);
      check_bit("ready_ex_o", ready_ex_o, data_gnt_i);  // low while stalled
      done = data_gnt_i;
      @(posedge clk);
      #1;
      if (!done)
        stalls++;
    end
    if (!done)
      report_timeout("grant");
  endtask

  // returns at the falling edge of the rvalid cycle
  task automatic wait_rvalid(input logic is_load, input logic [31:0] exp);
    int   n;
    logic done;
    done = 1'b0;
    for (n = 0; n < TMO && !done; n++)
    begin
      @(negedge clk);
      check_bit("busy_o", busy_o, 1'b1);
      check_bit("ready_wb_o", ready_wb_o, data_rvalid_i);
      if (data_rvalid_i)
      begin
        done = 1'b1;
        if (is_load)
          check_word("rdata_o", rdata_o, exp);         // bypass in the rvalid cycle
      end
      else
      begin
        check_bit("data_req_o", data_req_o, 1'b0);     // nothing new while waiting
        @(posedge clk);
        #1;
      end
    end
    if (!done)
      report_timeout("rvalid");
  endtask

  task automatic check_idle(input logic is_load, input logic [31:0] exp);
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("ready_wb_o", ready_wb_o, 1'b1);
    check_bit("ready_ex_o", ready_ex_o, 1'b1);
    check_bit("data_req_o", data_req_o, 1'b0);
    if (is_load)
      check_word("rdata_o", rdata_o, exp);             // held after rvalid
    @(posedge clk);
    #1;
  endtask

  // one full store or load access
  task automatic access(input lsu_req_t r, input logic [31:0] exp_rdata, output int gs);
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    gs = 0;
    if (timeouts > 0)
      return;
    addr    = req_addr(r);
    be      = be_for(r.size, addr[1:0]);
    wdata   = rotl_bytes(r.wdata, 2'(addr[1:0] - r.reg_offset));
    req_i   = 1'b1;
    lsu_req = r;
    wait_grant(addr, r.we, be, wdata, gs);
    req_i = 1'b0;
    wait_rvalid(!r.we, exp_rdata);
    @(posedge clk);
    #1;
    check_idle(!r.we, exp_rdata);
    if (r.we)
    begin
      exp_mem[addr[5:2]] = merge_bytes(exp_mem[addr[5:2]], wdata, be);
      check_word("mem", mem[addr[5:2]], exp_mem[addr[5:2]]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_word_store();
    int gs;
    access(make_req(1'b1, SIZE_WORD, EXT_ZERO, 32'h1234_5678, 2'd0, 32'h10, 32'h8, 1'b1),
           32'h0, gs);                                         // a + b = 0x18
    access(make_req(1'b1, SIZE_WORD, EXT_ZERO, 32'hcafe_f00d, 2'd0, 32'h24, 32'h100, 1'b0),
           32'h0, gs);                                         // b ignored
  endtask

  task automatic test_sub_stores();
    int        off;
    int        k;
    int        gs;
    lsu_size_e sz;
    for (k = 0; k < 4; k++)
    begin
      sz = SIZE_BYTE;
      if (k[0])
        sz = SIZE_BYTE_HI;    // both byte codes
      for (off = 0; off < 4; off++)
        access(make_req(1'b1, sz, EXT_ZERO, $random(seed), 2'(off + k), 32'h30,
                        32'(4 * k + off), 1'b1), 32'h0, gs);
      for (off = 0; off < 3; off++)
        access(make_req(1'b1, SIZE_HALF, EXT_ZERO, $random(seed), 2'(k - off), 32'h30,
                        32'(4 * k + off), 1'b1), 32'h0, gs);
    end
  endtask

  task automatic load_offsets(input lsu_ext_e ext);
    int off;
    int gs;
    for (off = 0; off < 4; off++)
      access(make_req(1'b0, SIZE_BYTE, ext, 32'h0, 2'd0, 32'h14, 32'(off), 1'b1),
             load_value(exp_mem[5], SIZE_BYTE, ext, 2'(off)), gs);
    for (off = 0; off < 3; off++)
      access(make_req(1'b0, SIZE_HALF, ext, 32'h0, 2'd0, 32'h14, 32'(off), 1'b1),
             load_value(exp_mem[5], SIZE_HALF, ext, 2'(off)), gs);
  endtask

  task automatic test_loads();
    int gs;
    // mixed sign bits in every lane
    access(make_req(1'b1, SIZE_WORD, EXT_ZERO, 32'h807f_ff01, 2'd0, 32'h14, 32'h0, 1'b1),
           32'h0, gs);
    load_offsets(EXT_ZERO);
    load_offsets(EXT_SIGN);
    load_offsets(EXT_ONES);
    access(make_req(1'b0, SIZE_WORD, EXT_SIGN, 32'h0, 2'd0, 32'h14, 32'h0, 1'b0),
           exp_mem[5], gs);
  endtask

  task automatic misaligned_case(input lsu_size_e size, input logic [1:0] off);
    int n;
    req_i   = 1'b1;
    lsu_req = make_req(1'b1, size, EXT_ZERO, 32'h5555_aaaa, 2'd0, 32'h20, {30'b0, off}, 1'b1);
    for (n = 0; n < 3; n++)
    begin
      @(negedge clk);
      check_bit("misaligned_o", misaligned_o, 1'b1);
      check_bit("data_req_o", data_req_o, 1'b0);      // never reaches the bus
      check_bit("ready_ex_o", ready_ex_o, 1'b1);
      check_bit("busy_o", busy_o, 1'b0);
      @(posedge clk);
      #1;
    end
    req_i = 1'b0;
  endtask

  task automatic test_misaligned();
    misaligned_case(SIZE_WORD, 2'd1);
    misaligned_case(SIZE_WORD, 2'd2);
    misaligned_case(SIZE_WORD, 2'd3);
    misaligned_case(SIZE_HALF, 2'd3);
    check_idle(1'b0, 32'h0);
  endtask

  task automatic test_backpressure();
    int gs;
    stall_next = 1'b1;  // picked up by the responder while idle
    @(posedge clk);
    #1;
    access(make_req(1'b0, SIZE_WORD, EXT_ZERO, 32'h0, 2'd0, 32'h14, 32'h0, 1'b1),
           exp_mem[5], gs);
    // responder counts only cycles with data_req_o high
    assert (timeouts > 0 || gs == 3)
    else
    begin
      errors++;
      $display("Grant did not come after exactly 3 request cycles, saw %0d stalls", gs);
    end
  endtask

  // second load waits behind the first and leaves in its rvalid cycle
  task automatic test_back_to_back();
    lsu_req_t    r1;
    lsu_req_t    r2;
    logic [31:0] e1;
    logic [31:0] e2;
    logic        hit;
    int          gs;
    if (timeouts > 0)
      return;
    r1 = make_req(1'b0, SIZE_BYTE, EXT_SIGN, 32'h0, 2'd0, 32'h14, 32'h3, 1'b1);
    r2 = make_req(1'b0, SIZE_HALF, EXT_ONES, 32'h0, 2'd0, 32'h32, 32'h0, 1'b0);
    e1 = load_value(exp_mem[5], SIZE_BYTE, EXT_SIGN, 2'd3);
    e2 = load_value(exp_mem[12], SIZE_HALF, EXT_ONES, 2'd2);
    req_i   = 1'b1;
    lsu_req = r1;
    wait_grant(32'h17, 1'b0, 4'b1000, 32'h0, gs);
    lsu_req = r2;   // held by the core until ready_ex_o
    wait_rvalid(1'b1, e1);
    if (timeouts > 0)
      return;
    check_bit("data_req_o", data_req_o, 1'b1);         // issued at once
    check_word("data_addr_o", data_addr_o, 32'h32);
    hit = data_gnt_i;
    @(posedge clk);
    #1;
    if (!hit)
      wait_grant(32'h32, 1'b0, 4'b1100, 32'h0, gs);
    req_i = 1'b0;
    wait_rvalid(1'b1, e2);
    @(posedge clk);
    #1;
    check_idle(1'b1, e2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    req_i         = 1'b0;
    lsu_req       = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = 32'h0;
    seed          = 22;
    errors        = 0;
    timeouts      = 0;
    gnt_cnt       = 0;
    rv_cnt        = 0;
    rv_pend       = 1'b0;
    stall_next    = 1'b0;
    long_rv       = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      mem[i]     = (i * 32'h1357_9bdf) ^ 32'h80ff_7f01;  // differs per word
      exp_mem[i] = mem[i];
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle(1'b0, 32'h0);   // reset values
    test_word_store();
    test_sub_stores();
    test_loads();
    test_misaligned();
    test_backpressure();
    test_back_to_back();
    $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- sources.f
lsu_pkg.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_access_ctrl.sv
lsu_top.sv
tb_lsu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_lsu -f sources.f -Mdir "$obj" -o sim_lsu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$obj/sim_lsu" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$log"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1
